/* commit_stimulus.txt */
# all numbers hex; beat: ack0 pc0 instr0 ex0 cause0 ack1 pc1 instr1 ex1 cause1
# reg_read addr value, reg_write addr data, det_expect det irq, trace_expect count sum, done name
beat 1 00000100 000000ef 0 00 1 00000200 000000ef 0 00
det_expect 1 0
beat 1 00000300 00000013 0 00 1 00000304 00008067 0 00
det_expect 2 0
beat 1 00000204 00000013 0 00 1 00000208 00008067 0 00
det_expect 2 0
beat 1 00000104 00000013 0 00 0 00000000 00000000 0 00
det_expect 0 0
reg_read 2 00000002
reg_read 3 00000002
reg_read 4 00000000
done nested_calls
beat 1 00000400 000000ef 0 00 1 00000500 00008067 0 00
det_expect 3 0
beat 1 00000600 00000013 0 00 0 00000000 00000000 0 00
det_expect 4 1
reg_read 4 00000001
reg_write 4 00000000
det_expect 0 0
done cfi_violation
beat 1 00000700 000002ef 0 00 1 00000800 00028067 0 00
det_expect 3 0
beat 1 00000900 00000013 1 02 1 00000080 00000013 0 00
det_expect 0 0
beat 1 00000084 00000073 1 0b 0 00000000 00000000 0 00
reg_read 1 00000002
reg_read 0 0000000d
reg_read 4 00000000
trace_expect 0000000d 00002c94
done exceptions
beat 1 00000a00 000000ef 0 00 1 00000a10 000000ef 0 00
beat 1 00000a20 000000ef 0 00 1 00000a30 000000ef 0 00
beat 1 00000a40 000000ef 0 00 1 00000a50 000000ef 0 00
beat 1 00000a60 000000ef 0 00 1 00000a70 000000ef 0 00
det_expect 1 0
beat 1 00000a80 000000ef 0 00 0 00000000 00000000 0 00
det_expect 9 0
beat 1 00000b00 00008067 0 00 1 00000a74 00008067 0 00
beat 1 00000a64 00008067 0 00 1 00000a54 00008067 0 00
beat 1 00000a44 00008067 0 00 1 00000a34 00008067 0 00
beat 1 00000a24 00008067 0 00 1 00000a14 00008067 0 00
det_expect 2 0
beat 1 00000a04 00008067 0 00 0 00000000 00000000 0 00
det_expect a 0
reg_read 2 0000000d
reg_read 3 0000000d
reg_read 4 00000000
done stack_errors
beat 1 00000c00 00000013 0 00 1 00000c04 00000013 0 00
beat 1 00000c08 00000013 0 00 1 00000c0c 00000013 0 00
beat 1 00000c10 00000013 0 00 1 00000c14 00000013 0 00
beat 1 00000c18 00000013 0 00 1 00000c1c 00000013 0 00
beat 1 00000c20 00000013 0 00 1 00000c24 00000013 0 00
beat 1 00000c28 00000013 0 00 1 00000c2c 00000013 0 00
trace_expect 0000002b 000176bc
reg_read 0 0000002b
done trace_random_ack
reg_write 2 12345678
reg_read 2 12345678
reg_write 5 ffffffff
reg_read 5 00000000
reg_read 6 00000000
reg_read 7 00000000
reg_write 4 00000003
det_expect 0 1
reg_write 4 00000000
det_expect 0 0
done register_access

/* vlog.f */
commit_mon_pkg.sv
cfi_shadow_stack.sv
perf_counters.sv
pc_fifo.sv
pc_trace_arbiter.sv
commit_monitor.sv
tb_commit_monitor.sv

/* run.sh */
#!/bin/sh
# build the commit monitor testbench with Verilator and run it
# the run passes only if the simulation output holds the pass message

verilator --binary --timing -Wno-fatal --timescale 1ns/1ns \
  --top-module tb_commit_monitor -f vlog.f -o tb_commit_monitor \
  && ./obj_dir/tb_commit_monitor | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
  && { echo "simulation run succeeded"; exit 0; } \
  || { echo "simulation run did not succeed"; exit 1; }

/* tb_commit_monitor.sv */
// testbench for the commit monitor
// replays commit beats and host accesses from the stimulus file and
// checks detection, counters, interrupt and the merged pc trace

`timescale 1ns/1ns

module tb_commit_monitor;

  localparam int NR_COMMIT_PORTS = 2;
  localparam int REG_TIMEOUT     = 50;
  localparam int TRACE_TIMEOUT   = 2000;

  logic                                         clk;
  logic                                         rst_n;
  logic                   [NR_COMMIT_PORTS-1:0] commit_ack;
  commit_mon_pkg::pc_t    [NR_COMMIT_PORTS-1:0] commit_pc;
  commit_mon_pkg::instr_t [NR_COMMIT_PORTS-1:0] commit_instr;
  logic                   [NR_COMMIT_PORTS-1:0] commit_ex_valid;
  commit_mon_pkg::cause_t [NR_COMMIT_PORTS-1:0] commit_cause;
  logic                                         reg_req;
  logic                                         reg_we;
  commit_mon_pkg::cnt_addr_t                    reg_addr;
  logic [commit_mon_pkg::XLEN-1:0]              reg_wdata;
  logic                                         reg_ack;
  logic [commit_mon_pkg::XLEN-1:0]              reg_rdata;
  logic                                         trace_req;
  commit_mon_pkg::pc_t                          trace_pc;
  logic                                         trace_ack;
  commit_mon_pkg::det_t                         detection;
  logic                                         cfi_irq;

  int unsigned error_count;
  int unsigned trace_errors;
  int unsigned check_count;
  int unsigned test_errors;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned rx_count;
  logic [31:0] rx_sum;

  commit_monitor #(
    .NR_COMMIT_PORTS ( NR_COMMIT_PORTS ),
    .RAS_DEPTH       ( 8               ),
    .PC_QUEUE_DEPTH  ( 16              )
  ) UUT (
    .clk_i             ( clk             ),
    .rst_ni            ( rst_n           ),
    .commit_ack_i      ( commit_ack      ),
    .commit_pc_i       ( commit_pc       ),
    .commit_instr_i    ( commit_instr    ),
    .commit_ex_valid_i ( commit_ex_valid ),
    .commit_cause_i    ( commit_cause    ),
    .reg_req_i         ( reg_req         ),
    .reg_we_i          ( reg_we          ),
    .reg_addr_i        ( reg_addr        ),
    .reg_wdata_i       ( reg_wdata       ),
    .reg_ack_o         ( reg_ack         ),
    .reg_rdata_o       ( reg_rdata       ),
    .trace_req_o       ( trace_req       ),
    .trace_pc_o        ( trace_pc        ),
    .trace_ack_i       ( trace_ack       ),
    .detection_o       ( detection       ),
    .cfi_irq_o         ( cfi_irq         )
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      test_errors++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d error(s)", name, test_errors);
    end
    test_errors = 0;
  endtask

  // full four-phase access, entered on a falling edge
  task automatic host_access(input logic we, input commit_mon_pkg::cnt_addr_t addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    reg_req   = 1'b1;
    reg_we    = we;
    reg_addr  = addr;
    reg_wdata = wdata;
    n = 0;
    while (!reg_ack && n < REG_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!reg_ack) begin
      $display("register port never acknowledged the request to address %0d", addr);
      error_count++;
      test_errors++;
    end
    rdata   = reg_rdata;
    reg_req = 1'b0;
    n = 0;
    while (reg_ack && n < REG_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (reg_ack) begin
      $display("register ack stayed high after the request was dropped");
      error_count++;
      test_errors++;
    end
  endtask

  // ------------------------------
  // trace consumer
  // ------------------------------
  initial begin : trace_consumer
    logic [31:0] lfsr_state;
    int          delay;
    int          n;
    lfsr_state   = 32'h3d02bb78;
    trace_ack    = 1'b0;
    rx_count     = 0;
    rx_sum       = '0;
    trace_errors = 0;
    forever begin
      @(negedge clk);
      if (rst_n && trace_req && !trace_ack) begin
        delay = 0;
        for (int b = 0; b < 2; b++) begin
          lfsr_state = lfsr_step(lfsr_state);
          delay      = (delay << 1) | int'(lfsr_state[0]);
        end
        for (int d = 0; d < delay; d++) begin
          @(negedge clk);
        end
        trace_ack = 1'b1;
        rx_count++;
        rx_sum = rx_sum + trace_pc;
        n = 0;
        while (trace_req && n < REG_TIMEOUT) begin
          @(negedge clk);
          n++;
        end
        if (trace_req) begin
          $display("trace request stayed high after ack");
          trace_errors++;
        end
        trace_ack = 1'b0;
      end
    end
  end

  // ------------------------------
  // stimulus replay
  // ------------------------------
  initial begin : stimulus_replay
    int          fd;
    int          nf;
    int          n;
    string       line;
    string       kind;
    string       name;
    logic [31:0] f [10];
    logic [31:0] rdata;

    error_count     = 0;
    check_count     = 0;
    test_errors     = 0;
    tests_run       = 0;
    tests_failed    = 0;
    rst_n           = 1'b0;
    commit_ack      = '0;
    commit_pc       = '0;
    commit_instr    = '0;
    commit_ex_valid = '0;
    commit_cause    = '0;
    reg_req         = 1'b0;
    reg_we          = 1'b0;
    reg_addr        = '0;
    reg_wdata       = '0;

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    compare_value("reg_ack after reset", 32'(reg_ack), 32'd0);
    compare_value("trace_req after reset", 32'(trace_req), 32'd0);
    compare_value("cfi_irq after reset", 32'(cfi_irq), 32'd0);
    compare_value("detection after reset", 32'(detection), 32'd0);
    finish_test("reset_values");

    fd = $fopen("commit_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open commit_stimulus.txt for reading");
      error_count++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        nf   = $fgets(line, fd);
        if (line.len() < 2 || line[0] == "#") begin
          continue;
        end
        nf = $sscanf(line, "%s", kind);
        @(negedge clk);
        if (kind == "beat") begin
          nf = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", kind, f[0], f[1],
                       f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
          if (nf != 11) begin
            $display("malformed beat record in stimulus file: %s", line);
            error_count++;
          end
          for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
            commit_ack[p]      = f[5*p][0];
            commit_pc[p]       = f[5*p+1];
            commit_instr[p]    = f[5*p+2];
            commit_ex_valid[p] = f[5*p+3][0];
            commit_cause[p]    = f[5*p+4][4:0];
          end
        end else begin
          commit_ack = '0;
          nf = $sscanf(line, "%s %h %h", kind, f[0], f[1]);
          case (kind)
            "reg_read": begin
              host_access(1'b0, commit_mon_pkg::cnt_addr_t'(f[0]), '0, rdata);
              compare_value($sformatf("counter %0d", f[0]), rdata, f[1]);
            end
            "reg_write": begin
              host_access(1'b1, commit_mon_pkg::cnt_addr_t'(f[0]), f[1], rdata);
            end
            "det_expect": begin
              compare_value("detection", 32'(detection), f[0]);
              compare_value("cfi_irq", 32'(cfi_irq), f[1]);
            end
            "trace_expect": begin
              n = 0;
              while (rx_count < f[0] && n < TRACE_TIMEOUT) begin
                @(negedge clk);
                n++;
              end
              if (rx_count < f[0]) begin
                $display("trace stalled with %0d of %0d pcs received", rx_count, f[0]);
                error_count++;
                test_errors++;
              end
              compare_value("traced pc count", rx_count, f[0]);
              compare_value("traced pc sum", rx_sum, f[1]);
            end
            "done": begin
              nf = $sscanf(line, "%s %s", kind, name);
              finish_test(name);
            end
            default: begin
              $display("unknown record kind %s in stimulus file", kind);
              error_count++;
            end
          endcase
        end
      end
      $fclose(fd);
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
             check_count, error_count + trace_errors);
    if (error_count + trace_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* commit_monitor.sv */
// standalone commit monitor
// shadow stack CFI check, event counters and merged pc trace
// attached to the commit ports of a core

`timescale 1ns/1ns

module commit_monitor #(
  parameter int NR_COMMIT_PORTS = 2,
  parameter int RAS_DEPTH       = 8,
  parameter int PC_QUEUE_DEPTH  = 16
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // commit ports, port 0 oldest
  input  logic                   [NR_COMMIT_PORTS-1:0] commit_ack_i,
  input  commit_mon_pkg::pc_t    [NR_COMMIT_PORTS-1:0] commit_pc_i,
  input  commit_mon_pkg::instr_t [NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  logic                   [NR_COMMIT_PORTS-1:0] commit_ex_valid_i,
  input  commit_mon_pkg::cause_t [NR_COMMIT_PORTS-1:0] commit_cause_i,
  // host register port
  input  logic                                         reg_req_i,
  input  logic                                         reg_we_i,
  input  commit_mon_pkg::cnt_addr_t                    reg_addr_i,
  input  logic [commit_mon_pkg::XLEN-1:0]              reg_wdata_i,
  output logic                                         reg_ack_o,
  output logic [commit_mon_pkg::XLEN-1:0]              reg_rdata_o,
  // trace output
  output logic                                         trace_req_o,
  output commit_mon_pkg::pc_t                          trace_pc_o,
  input  logic                                         trace_ack_i,
  output commit_mon_pkg::det_t                         detection_o,
  output logic                                         cfi_irq_o
);

  logic [NR_COMMIT_PORTS-1:0]                ev_call, ev_ret, ev_viol;
  logic [NR_COMMIT_PORTS-1:0]                fifo_empty, fifo_pop;
  commit_mon_pkg::pc_t [NR_COMMIT_PORTS-1:0] fifo_pc;

  // ------------------------------
  // CFI checker
  // ------------------------------
  cfi_shadow_stack #(
    .NR_COMMIT_PORTS ( NR_COMMIT_PORTS ),
    .RAS_DEPTH       ( RAS_DEPTH       )
  ) i_cfi_shadow_stack (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_pc_i       ( commit_pc_i       ),
    .commit_instr_i    ( commit_instr_i    ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .ev_call_o         ( ev_call           ),
    .ev_ret_o          ( ev_ret            ),
    .ev_viol_o         ( ev_viol           ),
    .detection_o       ( detection_o       )
  );

  // ------------------------------
  // counters
  // ------------------------------
  perf_counters #(
    .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
  ) i_perf_counters (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .ev_call_i         ( ev_call           ),
    .ev_ret_i          ( ev_ret            ),
    .ev_viol_i         ( ev_viol           ),
    .reg_req_i         ( reg_req_i         ),
    .reg_we_i          ( reg_we_i          ),
    .reg_addr_i        ( reg_addr_i        ),
    .reg_wdata_i       ( reg_wdata_i       ),
    .reg_ack_o         ( reg_ack_o         ),
    .reg_rdata_o       ( reg_rdata_o       ),
    .cfi_irq_o         ( cfi_irq_o         )
  );

  // ------------------------------
  // pc trace path
  // ------------------------------
  for (genvar i = 0; i < NR_COMMIT_PORTS; i++) begin : gen_pc_fifo
    pc_fifo #(
      .DEPTH ( PC_QUEUE_DEPTH )
    ) i_pc_fifo (
      .clk_i   ( clk_i                                      ),
      .rst_ni  ( rst_ni                                     ),
      .push_i  ( commit_ack_i[i] & ~commit_ex_valid_i[i]    ),
      .pc_i    ( commit_pc_i[i]                             ),
      .pop_i   ( fifo_pop[i]                                ),
      .pc_o    ( fifo_pc[i]                                 ),
      .empty_o ( fifo_empty[i]                              )
    );
  end

  pc_trace_arbiter #(
    .NR_PORTS ( NR_COMMIT_PORTS )
  ) i_pc_trace_arbiter (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .empty_i     ( fifo_empty  ),
    .pc_i        ( fifo_pc     ),
    .trace_ack_i ( trace_ack_i ),
    .pop_o       ( fifo_pop    ),
    .trace_req_o ( trace_req_o ),
    .trace_pc_o  ( trace_pc_o  )
  );

endmodule

/* pc_trace_arbiter.sv */
// round-robin merge of the pc queues into one trace stream
// drives the four-phase trace request and pops the granted queue

`timescale 1ns/1ns

module pc_trace_arbiter #(
  parameter int NR_PORTS = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                [NR_PORTS-1:0]  empty_i,
  input  commit_mon_pkg::pc_t [NR_PORTS-1:0]  pc_i,
  input  logic                                trace_ack_i,
  output logic                [NR_PORTS-1:0]  pop_o,
  output logic                                trace_req_o,
  output commit_mon_pkg::pc_t                 trace_pc_o
);

  localparam int IDX_W = (NR_PORTS > 1) ? $clog2(NR_PORTS) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT_LOW
  } state_e;

  state_e           state_q;
  logic [IDX_W-1:0] rr_q, grant_q;
  logic [IDX_W-1:0] sel_idx;
  logic             sel_valid;

  // ------------------------------
  // first non-empty from rr pointer
  // ------------------------------
  always_comb begin
    sel_idx   = '0;
    sel_valid = 1'b0;
    for (int k = 0; k < NR_PORTS; k++) begin
      if (!sel_valid && !empty_i[(int'(rr_q) + k) % NR_PORTS]) begin
        sel_idx   = IDX_W'((int'(rr_q) + k) % NR_PORTS);
        sel_valid = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      rr_q    <= '0;
      grant_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (sel_valid) begin
            grant_q <= sel_idx;
            state_q <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (trace_ack_i) begin
            // next search starts past the served port
            rr_q    <= (grant_q == IDX_W'(NR_PORTS - 1)) ? '0 : grant_q + 1'b1;
            state_q <= ST_WAIT_LOW;
          end
        end
        default: begin
          if (!trace_ack_i) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // head of a granted queue holds until its pop
  assign trace_req_o = (state_q == ST_REQ);
  assign trace_pc_o  = pc_i[grant_q];

  always_comb begin
    pop_o = '0;
    pop_o[grant_q] = (state_q == ST_REQ) && trace_ack_i;
  end

endmodule

/* pc_fifo.sv */
// queue of committed pcs for one commit port
// circular buffer with a fill count, pushes to a full queue are dropped

`timescale 1ns/1ns

module pc_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                push_i,
  input  commit_mon_pkg::pc_t pc_i,
  input  logic                pop_i,
  output commit_mon_pkg::pc_t pc_o,
  output logic                empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  commit_mon_pkg::pc_t mem_q [DEPTH];
  logic [PTR_W-1:0]    rd_ptr_q, wr_ptr_q;
  logic [CNT_W-1:0]    count_q;
  logic                do_push, do_pop;

  assign do_push = push_i && (count_q != CNT_W'(DEPTH));
  assign do_pop  = pop_i && (count_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // push and pop together leave the count unchanged
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= pc_i;
    end
  end

  assign pc_o    = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);

endmodule

/* perf_counters.sv */
// commit event counters with a four-phase register port
// raises the CFI interrupt while the violation counter is non-zero

`timescale 1ns/1ns

module perf_counters #(
  parameter int NR_COMMIT_PORTS = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [NR_COMMIT_PORTS-1:0]           commit_ack_i,
  input  logic [NR_COMMIT_PORTS-1:0]           commit_ex_valid_i,
  input  logic [NR_COMMIT_PORTS-1:0]           ev_call_i,
  input  logic [NR_COMMIT_PORTS-1:0]           ev_ret_i,
  input  logic [NR_COMMIT_PORTS-1:0]           ev_viol_i,
  input  logic                                 reg_req_i,
  input  logic                                 reg_we_i,
  input  commit_mon_pkg::cnt_addr_t            reg_addr_i,
  input  logic [commit_mon_pkg::XLEN-1:0]      reg_wdata_i,
  output logic                                 reg_ack_o,
  output logic [commit_mon_pkg::XLEN-1:0]      reg_rdata_o,
  output logic                                 cfi_irq_o
);

  localparam int NCNT = commit_mon_pkg::NR_COUNTERS;

  logic [commit_mon_pkg::XLEN-1:0] cnt_q [NCNT];
  logic [commit_mon_pkg::XLEN-1:0] inc   [NCNT];
  logic [commit_mon_pkg::XLEN-1:0] rdata_q;
  logic                            ack_q;
  logic                            access;

  function automatic logic [commit_mon_pkg::XLEN-1:0] popcnt(
    input logic [NR_COMMIT_PORTS-1:0] v
  );
    logic [commit_mon_pkg::XLEN-1:0] n;
    n = '0;
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
      n = n + commit_mon_pkg::XLEN'(v[i]);
    end
    return n;
  endfunction

  // per-cycle increments
  always_comb begin
    inc[commit_mon_pkg::CNT_INSTR]  = popcnt(commit_ack_i & ~commit_ex_valid_i);
    inc[commit_mon_pkg::CNT_EXCEPT] = popcnt(commit_ack_i & commit_ex_valid_i);
    inc[commit_mon_pkg::CNT_CALL]   = popcnt(ev_call_i);
    inc[commit_mon_pkg::CNT_RET]    = popcnt(ev_ret_i);
    inc[commit_mon_pkg::CNT_VIOL]   = popcnt(ev_viol_i);
  end

  // request seen while ack still low
  assign access = reg_req_i && !ack_q;

  // ------------------------------
  // counters, host write wins
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NCNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NCNT; i++) begin
        if (access && reg_we_i && reg_addr_i == commit_mon_pkg::cnt_addr_t'(i)) begin
          cnt_q[i] <= reg_wdata_i;
        end else begin
          cnt_q[i] <= cnt_q[i] + inc[i];
        end
      end
    end
  end

  // ------------------------------
  // four-phase handshake
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end else if (access) begin
      ack_q <= 1'b1;
      if (!reg_we_i) begin
        // unmapped addresses read zero
        rdata_q <= (int'(reg_addr_i) < NCNT) ? cnt_q[reg_addr_i] : '0;
      end
    end else if (!reg_req_i) begin
      ack_q <= 1'b0;
    end
  end

  assign reg_ack_o   = ack_q;
  assign reg_rdata_o = rdata_q;
  assign cfi_irq_o   = |cnt_q[commit_mon_pkg::CNT_VIOL];

endmodule

/* cfi_shadow_stack.sv */
// control-flow integrity checker on the commit ports
// keeps a shadow return stack, checks every committed return target
// and reports call, return, violation and stack error events

`timescale 1ns/1ns

module cfi_shadow_stack #(
  parameter int NR_COMMIT_PORTS = 2,
  parameter int RAS_DEPTH       = 8
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                 [NR_COMMIT_PORTS-1:0]   commit_ack_i,
  input  commit_mon_pkg::pc_t    [NR_COMMIT_PORTS-1:0] commit_pc_i,
  input  commit_mon_pkg::instr_t [NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  logic                 [NR_COMMIT_PORTS-1:0]   commit_ex_valid_i,
  output logic                 [NR_COMMIT_PORTS-1:0]   ev_call_o,
  output logic                 [NR_COMMIT_PORTS-1:0]   ev_ret_o,
  output logic                 [NR_COMMIT_PORTS-1:0]   ev_viol_o,
  output commit_mon_pkg::det_t                         detection_o
);

  localparam int SP_W  = $clog2(RAS_DEPTH + 1);
  localparam int IDX_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;

  commit_mon_pkg::pc_t stack_q [RAS_DEPTH];
  commit_mon_pkg::pc_t stack_d [RAS_DEPTH];
  logic [SP_W-1:0]     sp_q, sp_d;
  logic                pend_q, pend_d;
  commit_mon_pkg::pc_t tgt_q, tgt_d;
  logic                stack_err;
  commit_mon_pkg::det_t det_q;

  logic [NR_COMMIT_PORTS-1:0] is_call, is_ret;

  // ------------------------------
  // decode
  // ------------------------------
  for (genvar i = 0; i < NR_COMMIT_PORTS; i++) begin : gen_decode
    logic [6:0] opc;
    logic [4:0] rd, rs1;
    assign opc = commit_instr_i[i][6:0];
    assign rd  = commit_instr_i[i][11:7];
    assign rs1 = commit_instr_i[i][19:15];
    // jal/jalr writing a link register
    assign is_call[i] = (opc == commit_mon_pkg::OPC_JAL || opc == commit_mon_pkg::OPC_JALR) &&
                        (rd == commit_mon_pkg::REG_RA || rd == commit_mon_pkg::REG_T0);
    // jalr through a link register, result discarded
    assign is_ret[i]  = (opc == commit_mon_pkg::OPC_JALR) && (rd == 5'd0) &&
                        (rs1 == commit_mon_pkg::REG_RA || rs1 == commit_mon_pkg::REG_T0);
  end

  // ------------------------------
  // walk ports oldest first
  // ------------------------------
  always_comb begin
    stack_d   = stack_q;
    sp_d      = sp_q;
    pend_d    = pend_q;
    tgt_d     = tgt_q;
    stack_err = 1'b0;
    ev_call_o = '0;
    ev_ret_o  = '0;
    ev_viol_o = '0;
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
      if (commit_ack_i[i]) begin
        if (commit_ex_valid_i[i]) begin
          // trap redirects flow, drop the pending check
          pend_d = 1'b0;
        end else begin
          // return target check comes before this instruction's own effect
          if (pend_d) begin
            ev_viol_o[i] = (commit_pc_i[i] != tgt_d);
            pend_d       = 1'b0;
          end
          if (is_call[i]) begin
            ev_call_o[i] = 1'b1;
            if (sp_d == SP_W'(RAS_DEPTH)) begin
              stack_err = 1'b1;
            end else begin
              stack_d[sp_d[IDX_W-1:0]] = commit_pc_i[i] + commit_mon_pkg::pc_t'(4);
              sp_d = sp_d + 1'b1;
            end
          end
          if (is_ret[i]) begin
            ev_ret_o[i] = 1'b1;
            if (sp_d == '0) begin
              stack_err = 1'b1;
            end else begin
              sp_d   = sp_d - 1'b1;
              tgt_d  = stack_d[sp_d[IDX_W-1:0]];
              pend_d = 1'b1;
            end
          end
        end
      end
    end
  end

  // ------------------------------
  // state
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sp_q   <= '0;
      pend_q <= 1'b0;
      det_q  <= '0;
    end else begin
      sp_q   <= sp_d;
      pend_q <= pend_d;
      det_q[commit_mon_pkg::DET_CALL]      <= |ev_call_o;
      det_q[commit_mon_pkg::DET_RET]       <= |ev_ret_o;
      det_q[commit_mon_pkg::DET_VIOL]      <= |ev_viol_o;
      det_q[commit_mon_pkg::DET_STACK_ERR] <= stack_err;
    end
  end

  // return addresses and pending target
  always_ff @(posedge clk_i) begin
    stack_q <= stack_d;
    tgt_q   <= tgt_d;
  end

  assign detection_o = det_q;

endmodule

/* commit_mon_pkg.sv */
// commit monitor shared definitions
// widths, RISC-V opcode and link register constants, detection bits
// and the counter address map

package commit_mon_pkg;

  // ------------------------------
  // widths and base types
  // ------------------------------
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] pc_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      cause_t;

  // ------------------------------
  // instruction decode constants
  // ------------------------------
  localparam logic [6:0] OPC_JAL  = 7'b1101111;
  localparam logic [6:0] OPC_JALR = 7'b1100111;

  // link registers x1 and x5
  localparam logic [4:0] REG_RA = 5'd1;
  localparam logic [4:0] REG_T0 = 5'd5;

  // ------------------------------
  // per-cycle detection vector
  // ------------------------------
  typedef logic [3:0] det_t;

  localparam int DET_CALL      = 0;
  localparam int DET_RET       = 1;
  localparam int DET_VIOL      = 2;
  localparam int DET_STACK_ERR = 3;

  // ------------------------------
  // counter address map
  // ------------------------------
  typedef logic [2:0] cnt_addr_t;

  localparam cnt_addr_t CNT_INSTR  = 3'd0;
  localparam cnt_addr_t CNT_EXCEPT = 3'd1;
  localparam cnt_addr_t CNT_CALL   = 3'd2;
  localparam cnt_addr_t CNT_RET    = 3'd3;
  localparam cnt_addr_t CNT_VIOL   = 3'd4;

  // addresses at or above this read zero
  localparam int NR_COUNTERS = 5;

endpackage
